/* verilog/adc_cmd_pkg.sv */
package adc_cmd_pkg;

    // channel address selecting Vin0 .. Vin7
    typedef logic [2:0] chan_t;

    // control word shifted into the ADC msb first
    typedef struct packed {
        logic       write;     // 1 = update control register
        logic       seq;       // sequencer enable, unused here
        logic       dont_care;
        chan_t      addr;      // channel for the next conversion
        logic [1:0] pm;        // power mode
        logic       shadow;    // shadow register enable
        logic       spare;
        logic       range;     // 0 = 0 V to 2*Vref
        logic       coding;    // 0 = two's complement
        logic [3:0] pad;       // trailing don't care bits
    } ctrl_word_t;

    // word returned by the ADC during the same frame
    typedef struct packed {
        logic        lead;     // always zero from a healthy part
        chan_t       addr;     // channel this conversion came from
        logic [11:0] code;
    } result_word_t;

    // control field values
    localparam logic [1:0] PM_NORMAL   = 2'b11;  // full power
    localparam logic       RANGE_2VREF = 1'b0;
    localparam logic       CODING_TWOS = 1'b0;

endpackage

/* verilog/adc_stream_pkg.sv */
package adc_stream_pkg;

    // one converted sample as handed to the host
    typedef struct packed {
        logic signed [11:0] data;   // two's complement code
        adc_cmd_pkg::chan_t chan;   // channel the code belongs to
        logic [1:0]         error;  // see bit positions below
    } sample_t;

    // error field bit positions
    localparam int ERR_ADDR = 0;  // returned address not the one sent a frame earlier
    localparam int ERR_LEAD = 1;  // leading bit of the returned word was set

endpackage

/* verilog/adc_cmd_sequencer.sv */
`timescale 1ns/1ns

module adc_cmd_sequencer #(
    parameter int STARTUP_FRAMES = 3
) (
    input  logic                    sclk,
    input  logic                    arst_n,
    input  logic                    sample,
    input  adc_cmd_pkg::chan_t      chan,
    input  logic                    busy,
    output logic                    start,
    output adc_cmd_pkg::ctrl_word_t tx_word,
    output logic                    frame_active,
    output adc_cmd_pkg::chan_t      sent_chan
);

    import adc_cmd_pkg::*;

    // counter wide enough to hold STARTUP_FRAMES
    localparam int CNT_W = ($clog2(STARTUP_FRAMES + 1) > 0) ? $clog2(STARTUP_FRAMES + 1) : 1;

    logic [CNT_W-1:0] startup_cnt;  // power-up frames still to send
    logic             in_startup;
    logic             accept;
    ctrl_word_t       cmd_word;

    assign in_startup = (startup_cnt != '0);

    // strobes landing on a running or pending frame are dropped
    assign accept = sample && !busy && !start;

    // write command for the requested channel
    always_comb begin
        cmd_word.write     = 1'b1;
        cmd_word.seq       = 1'b0;
        cmd_word.dont_care = 1'b0;
        cmd_word.addr      = chan;
        cmd_word.pm        = PM_NORMAL;
        cmd_word.shadow    = 1'b0;
        cmd_word.spare     = 1'b0;
        cmd_word.range     = RANGE_2VREF;
        cmd_word.coding    = CODING_TWOS;
        cmd_word.pad       = 4'b0000;
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            startup_cnt  <= CNT_W'(STARTUP_FRAMES);
            start        <= 1'b0;
            frame_active <= 1'b0;
        end else begin
            start        <= accept;
            frame_active <= accept && !in_startup;  // only real conversions
            if (accept && in_startup) begin
                startup_cnt <= startup_cnt - 1'b1;
            end
        end
    end

    // command payload held while the shifter runs
    always_ff @(posedge sclk) begin
        if (accept) begin
            sent_chan <= chan;
            if (in_startup) begin
                tx_word <= '0;  // dummy frames wake the part up
            end else begin
                tx_word <= cmd_word;
            end
        end
    end

endmodule

/* verilog/spi_word_shifter.sv */
`timescale 1ns/1ns

module spi_word_shifter #(
    parameter int WORD_BITS = 16
) (
    input  logic                 sclk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic [WORD_BITS-1:0] tx_word,
    input  logic                 sdi,
    output logic                 cs,
    output logic                 sdo,
    output logic                 busy,
    output logic                 done,
    output logic [WORD_BITS-1:0] rx_word
);

    localparam int CNT_W = ($clog2(WORD_BITS) > 0) ? $clog2(WORD_BITS) : 1;

    logic [WORD_BITS-1:0] tx_sr;    // bits still to go out with the msb next
    logic [WORD_BITS-1:0] rx_sr;    // bits captured from the ADC
    logic [CNT_W-1:0]     bit_cnt;  // bits captured so far in this frame
    logic                 load;
    logic                 last_bit;

    assign load     = start && !busy;
    assign last_bit = busy && (bit_cnt == CNT_W'(WORD_BITS - 1));

    // cs stays low for exactly WORD_BITS cycles per frame
    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            cs      <= 1'b1;
            sdo     <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                cs      <= 1'b0;
                busy    <= 1'b1;
                sdo     <= tx_word[WORD_BITS-1];  // msb goes out with cs
                bit_cnt <= '0;
            end else if (last_bit) begin
                cs      <= 1'b1;
                busy    <= 1'b0;
                done    <= 1'b1;  // rx_word complete now
                sdo     <= 1'b0;
                bit_cnt <= '0;
            end else if (busy) begin
                sdo     <= tx_sr[WORD_BITS-1];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // shift registers
    always_ff @(posedge sclk) begin
        if (load) begin
            tx_sr <= tx_word << 1;
        end else if (busy) begin
            tx_sr <= tx_sr << 1;
            rx_sr <= {rx_sr[WORD_BITS-2:0], sdi};  // sample sdi on rising edge
        end
    end

    // rx_sr stops shifting at the end of the frame, so it holds the word
    assign rx_word = rx_sr;

endmodule

/* verilog/adc_result_unpack.sv */
`timescale 1ns/1ns

module adc_result_unpack (
    input  logic                      sclk,
    input  logic                      arst_n,
    input  logic                      done,
    input  logic                      frame_active,
    input  adc_cmd_pkg::chan_t        sent_chan,
    input  adc_cmd_pkg::result_word_t rx_word,
    output adc_stream_pkg::sample_t   sample_out,
    output logic                      sample_valid
);

    import adc_cmd_pkg::*;
    import adc_stream_pkg::*;

    // one frame in flight at a time, so a single entry is enough
    logic       pend_active;  // frame on the wire is a real conversion
    chan_t      pend_chan;    // address sent in that frame
    logic       prev_valid;   // an earlier active frame has completed
    chan_t      prev_chan;    // address sent in that earlier frame
    logic       take;
    logic [1:0] err;

    assign take = done && pend_active;

    // the ADC answers with the channel requested one frame before
    always_comb begin
        err           = 2'b00;
        err[ERR_LEAD] = rx_word.lead;
        err[ERR_ADDR] = prev_valid && (rx_word.addr != prev_chan);
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            pend_active  <= 1'b0;
            prev_valid   <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= take;
            if (frame_active) begin
                pend_active <= 1'b1;
            end else if (done) begin
                pend_active <= 1'b0;  // startup frames end here unnoticed
            end
            if (take) begin
                prev_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (frame_active) begin
            pend_chan <= sent_chan;
        end
        if (take) begin
            prev_chan        <= pend_chan;  // reference for the next frame
            sample_out.data  <= $signed(rx_word.code);
            sample_out.chan  <= rx_word.addr;
            sample_out.error <= err;
        end
    end

endmodule

/* verilog/adc_capture_top.sv */
`timescale 1ns/1ns

module adc_capture_top #(
    parameter int STARTUP_FRAMES = 3,
    parameter int WORD_BITS      = 16
) (
    input  logic                    sclk,
    input  logic                    arst_n,
    input  logic                    sample,
    input  adc_cmd_pkg::chan_t      chan,
    input  logic                    sdi,
    output logic                    cs,
    output logic                    sdo,
    output adc_stream_pkg::sample_t sample_out,
    output logic                    sample_valid
);

    import adc_cmd_pkg::*;

    logic         start;
    logic         busy;
    logic         done;
    logic         frame_active;
    ctrl_word_t   tx_word;    // command for the frame being sent
    result_word_t rx_word;    // word captured during that frame
    chan_t        sent_chan;

    adc_cmd_sequencer #(
        .STARTUP_FRAMES (STARTUP_FRAMES)
    ) adc_cmd_sequencer_i (
        .sclk         (sclk),
        .arst_n       (arst_n),
        .sample       (sample),
        .chan         (chan),
        .busy         (busy),
        .start        (start),
        .tx_word      (tx_word),
        .frame_active (frame_active),
        .sent_chan    (sent_chan)
    );

    spi_word_shifter #(
        .WORD_BITS (WORD_BITS)
    ) spi_word_shifter_i (
        .sclk    (sclk),
        .arst_n  (arst_n),
        .start   (start),
        .tx_word (tx_word),
        .sdi     (sdi),
        .cs      (cs),
        .sdo     (sdo),
        .busy    (busy),
        .done    (done),
        .rx_word (rx_word)
    );

    adc_result_unpack adc_result_unpack_i (
        .sclk         (sclk),
        .arst_n       (arst_n),
        .done         (done),
        .frame_active (frame_active),
        .sent_chan    (sent_chan),
        .rx_word      (rx_word),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

endmodule

/* bench/adc_model.sv */
`timescale 1ns/1ns

module adc_model (
    input  logic                    sclk,
    input  logic                    cs,
    input  logic                    sdo,
    output logic                    sdi,
    input  logic [7:0][11:0]        codes,       // preset conversion result per channel
    input  logic                    force_lead,  // answer with the lead bit set
    input  logic                    force_addr,  // answer with a wrong channel address
    output adc_cmd_pkg::ctrl_word_t last_cmd,
    output int                      frame_count
);

    import adc_cmd_pkg::*;

    chan_t        conv_chan;  // channel converted during the next frame
    result_word_t resp;       // word shifted out in the current frame
    logic [15:0]  rx_sr;      // control word collected from sdo
    ctrl_word_t   cmd;
    int           bit_idx;    // bit position moving in this half cycle

    initial begin
        sdi         = 1'b0;
        conv_chan   = '0;  // power-up default is Vin0
        resp        = '0;
        rx_sr       = '0;
        cmd         = '0;
        last_cmd    = '0;
        frame_count = 0;
        bit_idx     = 15;
    end

    // the controller moves bits on rising edges, so the model works on falling ones
    always @(negedge sclk) begin
        if (cs) begin
            bit_idx = 15;
            sdi <= 1'b0;
        end else begin
            if (bit_idx == 15) begin
                resp.lead = force_lead;
                resp.addr = force_addr ? (conv_chan ^ 3'b001) : conv_chan;
                resp.code = codes[conv_chan];
            end
            sdi <= resp[bit_idx];
            rx_sr[bit_idx] = sdo;
            if (bit_idx == 0) begin
                cmd = rx_sr;
                last_cmd <= cmd;
                frame_count <= frame_count + 1;
                // a write selects the channel for the following frame
                if (cmd.write && cmd.pm == PM_NORMAL) begin
                    conv_chan = cmd.addr;
                end
                bit_idx = 15;
            end else begin
                bit_idx = bit_idx - 1;
            end
        end
    end

endmodule

/* bench/adc_capture_tb.sv */
`timescale 1ns/1ns

module adc_capture_tb;

    import adc_cmd_pkg::*;
    import adc_stream_pkg::*;

    localparam int STARTUP_FRAMES = 3;
    localparam int WORD_BITS      = 16;
    localparam int NUM_ROWS       = 10;
    localparam int VALID_LATENCY  = 18;  // strobe edge to sample_valid edge
    localparam int WAIT_LIMIT     = 40;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + STARTUP_FRAMES) * 20 + 100;
    localparam logic [31:0] SEED  = 32'h9eb0;

    logic             sclk;
    logic             arst_n;
    logic             sample;
    chan_t            chan;
    logic             sdi;
    logic             cs;
    logic             sdo;
    sample_t          sample_out;
    logic             sample_valid;

    logic [7:0][11:0] codes;
    logic             force_lead;
    logic             force_addr;
    ctrl_word_t       model_cmd;
    int               model_frames;

    // stimulus table with expected samples filled in from the codes
    string            row_name [NUM_ROWS];
    chan_t            row_chan [NUM_ROWS];
    logic             row_lead [NUM_ROWS];
    logic             row_addr [NUM_ROWS];
    logic             row_dup  [NUM_ROWS];  // second strobe while cs is low
    sample_t          row_exp  [NUM_ROWS];

    int               test_bad;
    int               pass_count;
    int               fail_count;
    int               cycle_count;
    int               seed_val;

    adc_capture_top #(
        .STARTUP_FRAMES (STARTUP_FRAMES),
        .WORD_BITS      (WORD_BITS)
    ) adc_capture_top_i (
        .sclk         (sclk),
        .arst_n       (arst_n),
        .sample       (sample),
        .chan         (chan),
        .sdi          (sdi),
        .cs           (cs),
        .sdo          (sdo),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

    adc_model adc_model_i (
        .sclk        (sclk),
        .cs          (cs),
        .sdo         (sdo),
        .sdi         (sdi),
        .codes       (codes),
        .force_lead  (force_lead),
        .force_addr  (force_addr),
        .last_cmd    (model_cmd),
        .frame_count (model_frames)
    );

    initial begin
        sclk = 1'b0;
        forever #10 sclk = ~sclk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sclk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: run stopped after %0d cycles", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    function automatic ctrl_word_t expected_cmd(input chan_t c);
        ctrl_word_t w;
        w        = '0;
        w.write  = 1'b1;
        w.addr   = c;
        w.pm     = 2'b11;  // full power
        w.range  = 1'b0;
        w.coding = 1'b0;
        return w;
    endfunction

    task automatic set_row(input int i, input string name, input chan_t c,
                           input logic lead, input logic addr, input logic dup);
        row_name[i] = name;
        row_chan[i] = c;
        row_lead[i] = lead;
        row_addr[i] = addr;
        row_dup[i]  = dup;
    endtask

    task automatic fill_table();
        chan_t lag_chan;   // channel the ADC converts in the next frame
        chan_t ret_chan;
        logic  have_prev;
        set_row(0, "first_active", 3'd3, 1'b0, 1'b0, 1'b0);
        set_row(1, "lag_ch5",      3'd5, 1'b0, 1'b0, 1'b0);
        set_row(2, "lag_ch7_dup",  3'd7, 1'b0, 1'b0, 1'b1);
        set_row(3, "lag_ch0",      3'd0, 1'b0, 1'b0, 1'b0);
        set_row(4, "lead_err",     3'd2, 1'b1, 1'b0, 1'b0);
        set_row(5, "lag_ch6",      3'd6, 1'b0, 1'b0, 1'b0);
        set_row(6, "addr_err",     3'd1, 1'b0, 1'b1, 1'b0);
        set_row(7, "lag_ch4_dup",  3'd4, 1'b0, 1'b0, 1'b1);
        set_row(8, "both_err",     3'd4, 1'b1, 1'b1, 1'b0);
        set_row(9, "lag_ch3",      3'd3, 1'b0, 1'b0, 1'b0);
        lag_chan  = '0;  // startup words leave Vin0 selected
        have_prev = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            ret_chan = row_addr[i] ? (lag_chan ^ 3'b001) : lag_chan;
            row_exp[i].data  = codes[lag_chan];
            row_exp[i].chan  = ret_chan;
            row_exp[i].error = 2'b00;
            row_exp[i].error[ERR_LEAD] = row_lead[i];
            row_exp[i].error[ERR_ADDR] = have_prev && (ret_chan != lag_chan);
            lag_chan  = row_chan[i];
            have_prev = 1'b1;
        end
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected d=%0d ch=%0d err=%b, actual d=%0d ch=%0d err=%b",
                     name, exp.data, exp.chan, exp.error, act.data, act.chan, act.error);
            test_bad = 1;
        end
    endtask

    task automatic check_word(input string name, input ctrl_word_t exp, input ctrl_word_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected control word %h, actual %h", name, exp, act);
            test_bad = 1;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s: expected latency %0d cycles, actual %0d", name, exp, act);
            test_bad = 1;
        end
    endtask

    task automatic check_idle(input string name, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge sclk);
            @(negedge sclk);
            if (cs !== 1'b1) begin
                $display("%s: cs went low with no frame requested", name);
                test_bad = 1;
            end
            if (sample_valid !== 1'b0) begin
                $display("%s: extra sample_valid pulse after the sample", name);
                test_bad = 1;
            end
            if (adc_capture_top_i.done !== 1'b0) begin
                $display("%s: shifter raised done with no frame running", name);
                test_bad = 1;
            end
        end
    endtask

    // returns just after the edge that takes the strobe
    task automatic strobe_sample(input chan_t c);
        @(posedge sclk);
        #2;
        sample = 1'b1;
        chan   = c;
        @(posedge sclk);
        #2;
        sample = 1'b0;
    endtask

    task automatic report_test(input string name);
        if (test_bad) begin
            fail_count = fail_count + 1;
            $display("FAIL %s", name);
        end else begin
            pass_count = pass_count + 1;
            $display("PASS %s", name);
        end
        test_bad = 0;
    endtask

    task automatic run_startup(input int s);
        string name;
        int    frames0;
        int    cyc;
        logic  finished;
        logic  flagged;
        name     = $sformatf("startup_%0d", s);
        frames0  = model_frames;
        cyc      = 0;
        finished = 1'b0;
        flagged  = 1'b0;
        strobe_sample(3'd6);  // chan is ignored while powering up
        while (!finished && cyc < WAIT_LIMIT) begin
            @(posedge sclk);
            cyc = cyc + 1;
            @(negedge sclk);
            if (sample_valid && !flagged) begin
                $display("%s: sample_valid raised during a startup frame", name);
                test_bad = 1;
                flagged  = 1'b1;
            end
            if (cs && model_frames == frames0 + 1) begin
                finished = 1'b1;
            end
        end
        if (!finished) begin
            $display("%s: startup frame never completed", name);
            test_bad = 1;
        end else begin
            check_word(name, '0, model_cmd);
            check_idle(name, 1);
        end
        report_test(name);
    endtask

    task automatic run_row(input int i);
        int   cyc;
        logic got;
        cyc        = 0;
        got        = 1'b0;
        force_lead = row_lead[i];
        force_addr = row_addr[i];
        strobe_sample(row_chan[i]);
        while (!got && cyc < WAIT_LIMIT) begin
            @(posedge sclk);
            cyc = cyc + 1;
            if (row_dup[i] && cyc == 5) begin
                #2;
                sample = 1'b1;  // lands mid-frame on another channel and must be dropped
                chan   = row_chan[i] ^ 3'b010;
            end else if (cyc == 6) begin
                #2 sample = 1'b0;
            end
            @(negedge sclk);
            if (sample_valid) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            $display("%s: no sample_valid within %0d cycles", row_name[i], WAIT_LIMIT);
            test_bad = 1;
        end else begin
            check_cycles(row_name[i], VALID_LATENCY, cyc);
            check_sample(row_name[i], row_exp[i], sample_out);
            check_word(row_name[i], expected_cmd(row_chan[i]), model_cmd);
            check_idle(row_name[i], 2);
        end
        if (model_frames != STARTUP_FRAMES + i + 1) begin
            $display("mismatch %s: expected %0d ADC frames, actual %0d", row_name[i],
                     STARTUP_FRAMES + i + 1, model_frames);
            test_bad = 1;
        end
        report_test(row_name[i]);
    endtask

    initial begin
        arst_n     = 1'b0;
        sample     = 1'b0;
        chan       = '0;
        force_lead = 1'b0;
        force_addr = 1'b0;
        test_bad   = 0;
        pass_count = 0;
        fail_count = 0;
        seed_val   = $urandom(SEED);
        for (int c = 0; c < 8; c++) begin
            codes[c] = 12'($urandom() & 32'h0fff);
        end
        fill_table();

        repeat (4) @(posedge sclk);
        #2 arst_n = 1'b1;

        for (int s = 0; s < STARTUP_FRAMES; s++) begin
            run_startup(s);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/adc_cmd_pkg.sv
verilog/adc_stream_pkg.sv
verilog/adc_cmd_sequencer.sv
verilog/spi_word_shifter.sv
verilog/adc_result_unpack.sv
verilog/adc_capture_top.sv
bench/adc_model.sv
bench/adc_capture_tb.sv
